/* common/controlPkg.sv */
`default_nettype none

package controlPkg;

	typedef enum logic [5:0] {
		opR = 6'h00,
		opJ = 6'h02,
		opJal = 6'h03,
		opBeq = 6'h04,
		opBne = 6'h05,
		opBle = 6'h06,
		opBgt = 6'h07,
		opAddi = 6'h08,
		opAddiu = 6'h09,
		opSlti = 6'h0a,
		opLw = 6'h23,
		opSw = 6'h2b
	} opcodeT;

	typedef enum logic [5:0] {
		fnJr = 6'h08,
		fnBreak = 6'h0d,
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnSlt = 6'h2a
	} functT;

	typedef enum logic [3:0] {
		classAluReg,
		classAluImm,
		classSetLess,
		classLoad,
		classStore,
		classBranch,
		classJump,
		classJumpLink,
		classJumpReg,
		classHalt,
		classIllegal
	} instrClassT;

	typedef enum logic [1:0] {
		condEqual = 2'b00,
		condNotEqual = 2'b01,
		condLessEqual = 2'b10,
		condGreater = 2'b11
	} condKindT;

	typedef enum logic [2:0] {
		aluPass = 3'b000,
		aluAdd = 3'b001,
		aluSub = 3'b010,
		aluAnd = 3'b011,
		aluCompare = 3'b111
	} aluOpT;

	typedef enum logic [2:0] {
		iorPc = 3'b001,
		iorIllegalVector = 3'b010,
		iorOverflowVector = 3'b011,
		iorAluOut = 3'b101
	} iorDT;

	typedef enum logic [1:0] {
		srcAPc = 2'b00,
		srcARegA = 2'b10
	} aluSrcAT;

	typedef enum logic [2:0] {
		srcBRegB = 3'b000,
		srcBFour = 3'b010,
		srcBBranchOffset = 3'b011,
		srcBImmediate = 3'b100
	} aluSrcBT;

	typedef enum logic [1:0] {
		pcJumpTarget = 2'b00,
		pcAluResult = 2'b01,
		pcBranchTarget = 2'b11
	} pcSourceT;

	typedef enum logic [1:0] {
		dstRt = 2'b00,
		dstRd = 2'b01,
		dstRa = 2'b11
	} regDstT;

	typedef enum logic [3:0] {
		wbAluOut = 4'b0000,
		wbMdr = 4'b0001,
		wbPcLink = 4'b0101,
		wbZero = 4'b1001,
		wbOne = 4'b1010
	} memToRegT;

endpackage

`default_nettype wire

/* common/decodeIf.sv */
`default_nettype none

interface decodeIf;

	controlPkg::instrClassT instrClass;
	controlPkg::aluOpT aluOp;
	controlPkg::condKindT condKind;
	logic trapsOnOverflow;
	logic immediateOperand; // ALU B from immediate, rt as destination.

	modport producer (
		output instrClass,
		output aluOp,
		output condKind,
		output trapsOnOverflow,
		output immediateOperand
	);

	modport consumer (
		input instrClass,
		input aluOp,
		input condKind,
		input trapsOnOverflow,
		input immediateOperand
	);

endinterface

`default_nettype wire

/* control/instructionDecoder.sv */
`default_nettype none

module instructionDecoder (
	input controlPkg::opcodeT opcode,
	input controlPkg::functT funct,
	decodeIf.producer decode
);

	always_comb begin
		decode.instrClass = controlPkg::classIllegal;
		decode.aluOp = controlPkg::aluPass;
		decode.condKind = controlPkg::condEqual;
		decode.trapsOnOverflow = 1'b0;
		decode.immediateOperand = 1'b0;
		case (opcode)
			controlPkg::opR: begin
				case (funct)
					controlPkg::fnAdd: begin
						decode.instrClass = controlPkg::classAluReg;
						decode.aluOp = controlPkg::aluAdd;
						decode.trapsOnOverflow = 1'b1;
					end
					controlPkg::fnSub: begin
						decode.instrClass = controlPkg::classAluReg;
						decode.aluOp = controlPkg::aluSub;
						decode.trapsOnOverflow = 1'b1;
					end
					controlPkg::fnAnd: begin
						decode.instrClass = controlPkg::classAluReg;
						decode.aluOp = controlPkg::aluAnd;
					end
					controlPkg::fnSlt: begin
						decode.instrClass = controlPkg::classSetLess;
						decode.aluOp = controlPkg::aluCompare;
					end
					controlPkg::fnJr: decode.instrClass = controlPkg::classJumpReg;
					controlPkg::fnBreak: decode.instrClass = controlPkg::classHalt;
					default: decode.instrClass = controlPkg::classIllegal;
				endcase
			end
			controlPkg::opAddi, controlPkg::opAddiu: begin
				decode.instrClass = controlPkg::classAluImm;
				decode.aluOp = controlPkg::aluAdd;
				decode.immediateOperand = 1'b1;
				decode.trapsOnOverflow = (opcode == controlPkg::opAddi); // addiu never traps.
			end
			controlPkg::opSlti: begin
				decode.instrClass = controlPkg::classSetLess;
				decode.aluOp = controlPkg::aluCompare;
				decode.immediateOperand = 1'b1;
			end
			controlPkg::opBeq, controlPkg::opBne: begin
				decode.instrClass = controlPkg::classBranch;
				decode.aluOp = controlPkg::aluSub;
				decode.condKind = (opcode == controlPkg::opBeq) ?
					controlPkg::condEqual : controlPkg::condNotEqual;
			end
			controlPkg::opBle, controlPkg::opBgt: begin
				decode.instrClass = controlPkg::classBranch;
				decode.aluOp = controlPkg::aluCompare;
				decode.condKind = (opcode == controlPkg::opBle) ?
					controlPkg::condLessEqual : controlPkg::condGreater;
			end
			controlPkg::opLw, controlPkg::opSw: begin
				decode.instrClass = (opcode == controlPkg::opLw) ?
					controlPkg::classLoad : controlPkg::classStore;
				decode.aluOp = controlPkg::aluAdd; // Base plus offset.
				decode.immediateOperand = 1'b1;
			end
			controlPkg::opJ: decode.instrClass = controlPkg::classJump;
			controlPkg::opJal: decode.instrClass = controlPkg::classJumpLink;
			default: decode.instrClass = controlPkg::classIllegal;
		endcase
	end

endmodule

`default_nettype wire

/* control/conditionUnit.sv */
`default_nettype none

module conditionUnit (
	input logic clock,
	input logic reset,
	decodeIf.consumer decode,
	input logic sampleFlags,
	input logic zero,
	input logic overflow,
	input logic greater,
	output logic branchTaken,
	output logic overflowTrap
);

	logic takenNow;

	always_comb begin
		case (decode.condKind)
			controlPkg::condEqual: takenNow = zero;
			controlPkg::condNotEqual: takenNow = !zero;
			controlPkg::condLessEqual: takenNow = !greater;
			default: takenNow = greater;
		endcase
	end

	// Results hold until the next compare step.
	always_ff @(posedge clock) begin
		if (reset) begin
			branchTaken <= 1'b0;
			overflowTrap <= 1'b0;
		end else if (sampleFlags) begin
			branchTaken <= takenNow;
			overflowTrap <= overflow && decode.trapsOnOverflow;
		end
	end

endmodule

`default_nettype wire

/* control/cycleSequencer.sv */
`default_nettype none

module cycleSequencer (
	input logic clock,
	input logic reset,
	decodeIf.consumer decode,
	input logic lessThan,
	input logic branchTaken,
	input logic overflowTrap,
	output logic sampleFlags,
	output logic memReq,
	input logic memAck,
	output logic memWrite,
	output controlPkg::iorDT iorD,
	output controlPkg::aluSrcAT aluSrcA,
	output controlPkg::aluSrcBT aluSrcB,
	output controlPkg::aluOpT aluOp,
	output controlPkg::pcSourceT pcSource,
	output logic aluOrMem,
	output controlPkg::regDstT regDst,
	output controlPkg::memToRegT memToReg,
	output logic pcWrite,
	output logic regWrite,
	output logic irWrite,
	output logic mdrWrite,
	output logic aWrite,
	output logic bWrite,
	output logic aluOutWrite,
	output logic epcWrite
);

	typedef enum logic [4:0] {
		sIdle,
		sFetchReq,
		sFetchLatch,
		sFetchRelease,
		sDecode,
		sExecute,
		sWriteBack,
		sBranch,
		sMemReq,
		sMemLatch,
		sMemRelease,
		sLoadWrite,
		sJumpLink,
		sJump,
		sJumpReg,
		sTrapEpc,
		sTrapReq,
		sTrapLatch,
		sTrapRelease,
		sTrapJump,
		sHalt
	} stateT;

	stateT state;
	stateT nextState;
	logic lessReg; // Compare result kept for write-back.
	logic isStore;
	controlPkg::iorDT trapVector;

	assign isStore = (decode.instrClass == controlPkg::classStore);
	assign trapVector = (decode.instrClass == controlPkg::classIllegal) ?
		controlPkg::iorIllegalVector : controlPkg::iorOverflowVector;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= sIdle;
			lessReg <= 1'b0;
		end else begin
			state <= nextState;
			if (state == sExecute)
				lessReg <= lessThan;
		end
	end

	always_comb begin
		nextState = state;
		sampleFlags = 1'b0;
		memReq = 1'b0;
		memWrite = 1'b0;
		iorD = controlPkg::iorPc;
		aluSrcA = controlPkg::srcAPc; // Defaults form pc plus four.
		aluSrcB = controlPkg::srcBFour;
		aluOp = controlPkg::aluAdd;
		pcSource = controlPkg::pcAluResult;
		aluOrMem = 1'b0;
		regDst = controlPkg::dstRt;
		memToReg = controlPkg::wbAluOut;
		pcWrite = 1'b0;
		regWrite = 1'b0;
		irWrite = 1'b0;
		mdrWrite = 1'b0;
		aWrite = 1'b0;
		bWrite = 1'b0;
		aluOutWrite = 1'b0;
		epcWrite = 1'b0;
		case (state)
			sIdle: nextState = sFetchReq;
			sFetchReq: begin
				memReq = 1'b1;
				if (memAck)
					nextState = sFetchLatch;
			end
			sFetchLatch: begin
				irWrite = 1'b1;
				pcWrite = 1'b1;
				nextState = sFetchRelease;
			end
			sFetchRelease: begin
				if (!memAck)
					nextState = sDecode;
			end
			sDecode: begin
				aWrite = 1'b1;
				bWrite = 1'b1;
				aluOutWrite = 1'b1; // Branch target, used only by branches.
				aluSrcB = controlPkg::srcBBranchOffset;
				case (decode.instrClass)
					controlPkg::classJump: nextState = sJump;
					controlPkg::classJumpLink: nextState = sJumpLink;
					controlPkg::classJumpReg: nextState = sJumpReg;
					controlPkg::classHalt: nextState = sHalt;
					controlPkg::classIllegal: nextState = sTrapEpc;
					default: nextState = sExecute;
				endcase
			end
			sExecute: begin
				aluSrcA = controlPkg::srcARegA;
				aluSrcB = decode.immediateOperand ?
					controlPkg::srcBImmediate : controlPkg::srcBRegB;
				aluOp = decode.aluOp;
				case (decode.instrClass)
					controlPkg::classBranch: begin
						sampleFlags = 1'b1; // Keeps the branch target in aluOut.
						nextState = sBranch;
					end
					controlPkg::classLoad, controlPkg::classStore: begin
						aluOutWrite = 1'b1;
						nextState = sMemReq;
					end
					default: begin
						sampleFlags = 1'b1;
						aluOutWrite = 1'b1;
						nextState = sWriteBack;
					end
				endcase
			end
			sWriteBack: begin
				regWrite = !overflowTrap;
				regDst = decode.immediateOperand ? controlPkg::dstRt : controlPkg::dstRd;
				if (decode.instrClass == controlPkg::classSetLess)
					memToReg = lessReg ? controlPkg::wbOne : controlPkg::wbZero;
				nextState = overflowTrap ? sTrapEpc : sFetchReq;
			end
			sBranch: begin
				pcWrite = branchTaken;
				pcSource = controlPkg::pcBranchTarget;
				nextState = sFetchReq;
			end
			sMemReq: begin
				memReq = 1'b1;
				memWrite = isStore;
				iorD = controlPkg::iorAluOut;
				if (memAck)
					nextState = sMemLatch;
			end
			sMemLatch: begin
				memWrite = isStore;
				iorD = controlPkg::iorAluOut;
				mdrWrite = !isStore;
				nextState = sMemRelease;
			end
			sMemRelease: begin
				memWrite = isStore;
				iorD = controlPkg::iorAluOut;
				if (!memAck)
					nextState = isStore ? sFetchReq : sLoadWrite;
			end
			sLoadWrite: begin
				regWrite = 1'b1;
				memToReg = controlPkg::wbMdr;
				nextState = sFetchReq;
			end
			sJumpLink: begin
				regWrite = 1'b1;
				regDst = controlPkg::dstRa;
				memToReg = controlPkg::wbPcLink;
				nextState = sJump;
			end
			sJump: begin
				pcWrite = 1'b1;
				pcSource = controlPkg::pcJumpTarget;
				nextState = sFetchReq;
			end
			sJumpReg: begin
				pcWrite = 1'b1;
				aluSrcA = controlPkg::srcARegA;
				aluOp = controlPkg::aluPass;
				nextState = sFetchReq;
			end
			sTrapEpc: begin
				epcWrite = 1'b1;
				aluOp = controlPkg::aluSub; // Address of the faulting word.
				nextState = sTrapReq;
			end
			sTrapReq: begin
				memReq = 1'b1;
				iorD = trapVector;
				if (memAck)
					nextState = sTrapLatch;
			end
			sTrapLatch: begin
				iorD = trapVector;
				mdrWrite = 1'b1;
				nextState = sTrapRelease;
			end
			sTrapRelease: begin
				iorD = trapVector;
				if (!memAck)
					nextState = sTrapJump;
			end
			sTrapJump: begin
				pcWrite = 1'b1;
				aluOrMem = 1'b1; // Handler address from the MDR.
				nextState = sFetchReq;
			end
			sHalt: nextState = sHalt;
			default: nextState = sIdle;
		endcase
	end

endmodule

`default_nettype wire

/* source/controlUnit.sv */
`default_nettype none

module controlUnit (
	input logic clock,
	input logic reset,
	input logic [5:0] opcode,
	input logic [5:0] funct,
	input logic zero,
	input logic overflow,
	input logic greater,
	input logic lessThan,
	input logic memAck,
	output logic memReq,
	output logic memWrite,
	output controlPkg::iorDT iorD,
	output controlPkg::aluSrcAT aluSrcA,
	output controlPkg::aluSrcBT aluSrcB,
	output controlPkg::aluOpT aluOp,
	output controlPkg::pcSourceT pcSource,
	output logic aluOrMem,
	output controlPkg::regDstT regDst,
	output controlPkg::memToRegT memToReg,
	output logic pcWrite,
	output logic regWrite,
	output logic irWrite,
	output logic mdrWrite,
	output logic aWrite,
	output logic bWrite,
	output logic aluOutWrite,
	output logic epcWrite
);

	logic sampleFlags;
	logic branchTaken;
	logic overflowTrap;

	decodeIf decodeBus ();

	// Raw fields may hold codes outside the enums.
	instructionDecoder decoder (
		.opcode(controlPkg::opcodeT'(opcode)),
		.funct(controlPkg::functT'(funct)),
		.decode(decodeBus.producer)
	);

	conditionUnit conditions (
		.clock(clock),
		.reset(reset),
		.decode(decodeBus.consumer),
		.sampleFlags(sampleFlags),
		.zero(zero),
		.overflow(overflow),
		.greater(greater),
		.branchTaken(branchTaken),
		.overflowTrap(overflowTrap)
	);

	cycleSequencer sequencer (
		.clock(clock),
		.reset(reset),
		.decode(decodeBus.consumer),
		.lessThan(lessThan),
		.branchTaken(branchTaken),
		.overflowTrap(overflowTrap),
		.sampleFlags(sampleFlags),
		.memReq(memReq),
		.memAck(memAck),
		.memWrite(memWrite),
		.iorD(iorD),
		.aluSrcA(aluSrcA),
		.aluSrcB(aluSrcB),
		.aluOp(aluOp),
		.pcSource(pcSource),
		.aluOrMem(aluOrMem),
		.regDst(regDst),
		.memToReg(memToReg),
		.pcWrite(pcWrite),
		.regWrite(regWrite),
		.irWrite(irWrite),
		.mdrWrite(mdrWrite),
		.aWrite(aWrite),
		.bWrite(bWrite),
		.aluOutWrite(aluOutWrite),
		.epcWrite(epcWrite)
	);

endmodule

`default_nettype wire

/* bench/programTasks.svh */
int expRegWrites;
int expPcWrites;
int expReads;
int expWrites;
int expEpcWrites;
int expMdrWrites;
logic [1:0] expDst;
logic [3:0] expWb;
logic [1:0] expPcSrc;
logic expAluOrMem;
logic [2:0] expReadAddr;
logic expExecute;
logic [2:0] expSrcB;
logic [2:0] expAluOp;
logic expExecWrite;
logic expPassRegA;

// Expected activity between this fetch and the next one.
task automatic setExpected(input logic [5:0] op, input logic [5:0] fn,
	input logic z, input logic ov, input logic gt, input logic lt);
	int trap;
	trap = 0;
	expRegWrites = 0;
	expPcWrites = 0;
	expReads = 0;
	expWrites = 0;
	expEpcWrites = 0;
	expMdrWrites = 0;
	expDst = 2'b00;
	expWb = 4'b0000;
	expPcSrc = 2'b00;
	expAluOrMem = 1'b0;
	expReadAddr = 3'b101;
	expExecute = 1'b0;
	expSrcB = 3'b000;
	expAluOp = 3'b001;
	expExecWrite = 1'b1;
	expPassRegA = 1'b0;
	if (op == 6'h00 && (fn == 6'h20 || fn == 6'h22 || fn == 6'h24 || fn == 6'h2a)) begin
		expExecute = 1'b1;
		case (fn)
			6'h20: expAluOp = 3'b001;
			6'h22: expAluOp = 3'b010;
			6'h24: expAluOp = 3'b011;
			default: expAluOp = 3'b111;
		endcase
		if (ov && fn != 6'h24 && fn != 6'h2a)
			trap = 1;
		else begin
			expRegWrites = 1;
			expDst = 2'b01;
			expWb = (fn != 6'h2a) ? 4'b0000 : (lt ? 4'b1010 : 4'b1001);
		end
	end else if (op == 6'h00 && fn == 6'h08) begin
		expPcWrites = 1;
		expPcSrc = 2'b01;
		expPassRegA = 1'b1;
	end else if (op == 6'h08 || op == 6'h09 || op == 6'h0a) begin
		expExecute = 1'b1;
		expSrcB = 3'b100;
		expAluOp = (op != 6'h0a) ? 3'b001 : 3'b111;
		if (op == 6'h08 && ov)
			trap = 1;
		else begin
			expRegWrites = 1;
			expWb = (op != 6'h0a) ? 4'b0000 : (lt ? 4'b1010 : 4'b1001);
		end
	end else if (op == 6'h23) begin
		expExecute = 1'b1;
		expSrcB = 3'b100;
		expReads = 1;
		expMdrWrites = 1;
		expRegWrites = 1;
		expWb = 4'b0001;
	end else if (op == 6'h2b) begin
		expExecute = 1'b1;
		expSrcB = 3'b100;
		expWrites = 1;
	end else if (op >= 6'h04 && op <= 6'h07) begin
		expExecute = 1'b1;
		expExecWrite = 1'b0; // aluOut keeps the branch target.
		expAluOp = (op <= 6'h05) ? 3'b010 : 3'b111;
		expPcSrc = 2'b11;
		case (op)
			6'h04: expPcWrites = z;
			6'h05: expPcWrites = !z;
			6'h06: expPcWrites = !gt;
			default: expPcWrites = gt;
		endcase
	end else if (op == 6'h02 || op == 6'h03) begin
		expPcWrites = 1;
		if (op == 6'h03) begin
			expRegWrites = 1;
			expDst = 2'b11;
			expWb = 4'b0101;
		end
	end else begin
		trap = 2;
	end
	if (trap != 0) begin
		expEpcWrites = 1;
		expReads = 1;
		expMdrWrites = 1;
		expPcWrites = 1;
		expPcSrc = 2'b01;
		expAluOrMem = 1'b1;
		expReadAddr = (trap == 1) ? 3'b011 : 3'b010;
	end
endtask

// Hands the word to the DUT once the IR is written.
task automatic presentWord(input logic [5:0] op, input logic [5:0] fn,
	input logic z, input logic ov, input logic gt, input logic lt);
	int waited;
	waited = 0;
	do begin
		@(negedge clock);
		waited++;
		if (waited > 100)
			reportFailure("no irWrite seen for a fetch");
	end while (!irWrite);
	@(posedge clock);
	#1;
	opcode = op;
	funct = fn;
	zero = z;
	overflow = ov;
	greater = gt;
	lessThan = lt;
endtask

task automatic runInstruction(input logic [5:0] op, input logic [5:0] fn,
	input logic z, input logic ov, input logic gt, input logic lt);
	int cycles;
	int regWrites;
	int pcWrites;
	int reads;
	int writes;
	int epcWrites;
	int mdrWrites;
	int decodes;
	logic [1:0] dst;
	logic [3:0] wb;
	logic [1:0] pcSrc;
	logic pcFromMem;
	logic [1:0] pcSrcA;
	logic [2:0] pcAluOp;
	logic [2:0] readAddr;
	logic prevReq;
	logic afterDecode;
	logic done;
	cycles = 0;
	regWrites = 0;
	pcWrites = 0;
	reads = 0;
	writes = 0;
	epcWrites = 0;
	mdrWrites = 0;
	decodes = 0;
	dst = 2'b00;
	wb = 4'b0000;
	pcSrc = 2'b00;
	pcFromMem = 1'b0;
	pcSrcA = 2'b00;
	pcAluOp = 3'b000;
	readAddr = 3'b000;
	prevReq = 1'b0;
	afterDecode = 1'b0;
	done = 1'b0;
	setExpected(op, fn, z, ov, gt, lt);
	presentWord(op, fn, z, ov, gt, lt);
	while (!done) begin
		@(negedge clock);
		cycles++;
		if (cycles > 200)
			reportFailure("instruction never reached the next fetch");
		if (afterDecode && expExecute) begin
			checkValue("aluSrcA", aluSrcA, 2'b10);
			checkValue("aluSrcB", aluSrcB, expSrcB);
			checkValue("aluOp", aluOp, expAluOp);
			checkValue("aluOutWrite", aluOutWrite, expExecWrite);
		end
		afterDecode = aWrite;
		if (aWrite)
			decodes++;
		if (memReq && !prevReq) begin
			if (iorD == 3'b001 && !memWrite)
				done = 1'b1;
			else if (memWrite) begin
				writes++;
				checkValue("iorD", iorD, 3'b101);
			end else begin
				reads++;
				readAddr = iorD;
			end
		end
		if (regWrite) begin
			regWrites++;
			dst = regDst;
			wb = memToReg;
		end
		if (pcWrite) begin
			pcWrites++;
			pcSrc = pcSource;
			pcFromMem = aluOrMem;
			pcSrcA = aluSrcA;
			pcAluOp = aluOp;
		end
		if (epcWrite)
			epcWrites++;
		if (mdrWrite)
			mdrWrites++;
		prevReq = memReq;
	end
	checkValue("aWrite count", decodes, 1);
	checkValue("regWrite count", regWrites, expRegWrites);
	checkValue("pcWrite count", pcWrites, expPcWrites);
	checkValue("read count", reads, expReads);
	checkValue("write count", writes, expWrites);
	checkValue("epcWrite count", epcWrites, expEpcWrites);
	checkValue("mdrWrite count", mdrWrites, expMdrWrites);
	if (expRegWrites != 0) begin
		checkValue("regDst", dst, expDst);
		checkValue("memToReg", wb, expWb);
	end
	if (expPcWrites != 0) begin
		checkValue("pcSource", pcSrc, expPcSrc);
		checkValue("aluOrMem", pcFromMem, expAluOrMem);
	end
	if (expPassRegA) begin
		checkValue("aluSrcA", pcSrcA, 2'b10);
		checkValue("aluOp", pcAluOp, 3'b000);
	end
	if (expReads != 0)
		checkValue("iorD", readAddr, expReadAddr);
endtask

task automatic runHalt();
	presentWord(6'h00, 6'h0d, 0, 0, 0, 0);
	repeat (50) begin
		@(negedge clock);
		assert (!memReq) else reportFailure("memReq rose after break");
	end
endtask

/* bench/controlUnitBench.sv */
`default_nettype none

module controlUnitBench;

	timeunit 1ns;
	timeprecision 100ps;

	logic clock;
	logic reset;
	logic [5:0] opcode;
	logic [5:0] funct;
	logic zero;
	logic overflow;
	logic greater;
	logic lessThan;
	logic memAck;
	logic memReq;
	logic memWrite;
	logic [2:0] iorD;
	logic [1:0] aluSrcA;
	logic [2:0] aluSrcB;
	logic [2:0] aluOp;
	logic [1:0] pcSource;
	logic aluOrMem;
	logic [1:0] regDst;
	logic [3:0] memToReg;
	logic pcWrite;
	logic regWrite;
	logic irWrite;
	logic mdrWrite;
	logic aWrite;
	logic bWrite;
	logic aluOutWrite;
	logic epcWrite;
	integer seed;

	controlUnit u_controlUnit (
		.clock(clock), .reset(reset), .opcode(opcode), .funct(funct),
		.zero(zero), .overflow(overflow), .greater(greater), .lessThan(lessThan),
		.memAck(memAck), .memReq(memReq), .memWrite(memWrite), .iorD(iorD),
		.aluSrcA(aluSrcA), .aluSrcB(aluSrcB), .aluOp(aluOp), .pcSource(pcSource),
		.aluOrMem(aluOrMem), .regDst(regDst), .memToReg(memToReg),
		.pcWrite(pcWrite), .regWrite(regWrite), .irWrite(irWrite),
		.mdrWrite(mdrWrite), .aWrite(aWrite), .bWrite(bWrite),
		.aluOutWrite(aluOutWrite), .epcWrite(epcWrite)
	);

	task automatic reportFailure(input string message);
		$display("%s", message);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		assert (got === expected) else
			reportFailure($sformatf("Error %s got %h expected %h", name, got, expected));
	endtask

	`include "programTasks.svh"

	initial begin
		clock = 1'b0;
		forever #5 clock = !clock;
	end

	// Four-phase rules seen from the memory side.
	assert property (@(posedge clock) reset |=> !memReq && !memWrite && !pcWrite
		&& !regWrite && !irWrite && !mdrWrite && !aWrite && !bWrite
		&& !aluOutWrite && !epcWrite)
		else reportFailure("outputs were active right after reset");
	assert property (@(posedge clock) disable iff (reset) $rose(memReq) |-> !memAck)
		else reportFailure("memReq rose while memAck was still high");
	assert property (@(posedge clock) disable iff (reset) memReq && !memAck |=> memReq)
		else reportFailure("memReq dropped before memAck arrived");
	assert property (@(posedge clock) disable iff (reset)
		memReq && !memAck |=> $stable(iorD) && $stable(memWrite))
		else reportFailure("iorD or memWrite changed during a request");
	assert property (@(posedge clock) disable iff (reset) memReq && memAck |=> !memReq)
		else reportFailure("memReq stayed high after memAck");
	assert property (@(posedge clock) disable iff (reset)
		(irWrite || mdrWrite) |-> memAck && !memReq)
		else reportFailure("irWrite or mdrWrite pulsed outside the ack phase");

	// Fetch writes pc plus four, decode forms the branch target.
	assert property (@(posedge clock) disable iff (reset) irWrite |-> pcWrite
		&& pcSource == 2'b01 && aluSrcA == 2'b00 && aluSrcB == 3'b010 && aluOp == 3'b001)
		else reportFailure("fetch did not write pc plus four along with the IR");
	assert property (@(posedge clock) disable iff (reset)
		(aWrite || bWrite) |-> aWrite && bWrite && aluOutWrite
		&& aluSrcA == 2'b00 && aluSrcB == 3'b011 && aluOp == 3'b001)
		else reportFailure("decode did not latch the operands and the branch target");

	// Memory responder with random ack delay.
	initial begin
		int delay;
		int waited;
		seed = 32'h62e1;
		memAck = 1'b0;
		forever begin
			waited = 0;
			do begin
				@(negedge clock);
				waited++;
				if (waited > 1000)
					reportFailure("memory saw no request for too long");
			end while (!memReq);
			delay = 1 + ($unsigned($random(seed)) % 4);
			repeat (delay) @(posedge clock);
			#1 memAck = 1'b1;
			waited = 0;
			do begin
				@(negedge clock);
				waited++;
				if (waited > 50)
					reportFailure("memReq was not released after memAck");
			end while (memReq);
			@(posedge clock);
			#1 memAck = 1'b0;
		end
	end

	initial begin
		reset = 1'b1;
		opcode = 6'h00;
		funct = 6'h20;
		zero = 1'b0;
		overflow = 1'b0;
		greater = 1'b0;
		lessThan = 1'b0;
		repeat (16) @(posedge clock);
		#1 reset = 1'b0;
		runInstruction(6'h00, 6'h20, 0, 0, 0, 0); // add
		runInstruction(6'h00, 6'h22, 0, 0, 0, 0); // sub
		runInstruction(6'h00, 6'h24, 0, 1, 0, 0); // and ignores overflow.
		runInstruction(6'h00, 6'h2a, 0, 0, 0, 1);
		runInstruction(6'h00, 6'h2a, 0, 0, 0, 0);
		runInstruction(6'h08, 6'h00, 0, 0, 0, 0); // addi
		runInstruction(6'h09, 6'h00, 0, 1, 0, 0); // addiu never traps.
		runInstruction(6'h0a, 6'h00, 0, 0, 0, 1);
		runInstruction(6'h0a, 6'h00, 0, 0, 0, 0);
		runInstruction(6'h23, 6'h00, 0, 0, 0, 0); // lw
		runInstruction(6'h2b, 6'h00, 0, 0, 0, 0); // sw
		runInstruction(6'h04, 6'h00, 1, 0, 0, 0);
		runInstruction(6'h04, 6'h00, 0, 0, 0, 0);
		runInstruction(6'h05, 6'h00, 0, 0, 0, 0);
		runInstruction(6'h05, 6'h00, 1, 0, 0, 0);
		runInstruction(6'h06, 6'h00, 0, 0, 0, 0);
		runInstruction(6'h06, 6'h00, 0, 0, 1, 0);
		runInstruction(6'h07, 6'h00, 0, 0, 1, 0);
		runInstruction(6'h07, 6'h00, 0, 0, 0, 0);
		runInstruction(6'h02, 6'h00, 0, 0, 0, 0); // j
		runInstruction(6'h03, 6'h00, 0, 0, 0, 0); // jal
		runInstruction(6'h00, 6'h08, 0, 0, 0, 0); // jr
		runInstruction(6'h00, 6'h20, 0, 1, 0, 0); // add overflow trap.
		runInstruction(6'h08, 6'h00, 0, 1, 0, 0);
		runInstruction(6'h3f, 6'h00, 0, 0, 0, 0); // Unknown opcode.
		runInstruction(6'h00, 6'h3f, 0, 0, 0, 0); // Unknown funct.
		runHalt();
		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+bench
common/controlPkg.sv
common/decodeIf.sv
control/instructionDecoder.sv
control/conditionUnit.sv
control/cycleSequencer.sv
source/controlUnit.sv
bench/controlUnitBench.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module controlUnitBench -f src.f -o simv
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log
if grep -q "TESTS FAILED" sim.log; then
	exit 1
fi
grep -q "TESTS PASSED" sim.log
